// File: design/memCtrlPkg.sv
package memCtrlPkg;

    localparam int wordWidth    = 32;
    localparam int byteWidth    = 8;
    localparam int bytesPerWord = 4;

    // fetches always use len4
    typedef enum logic [1:0] {
        len1,
        len2,
        len4
    } accessLen_e;

    typedef enum logic [1:0] {
        kindFetch,
        kindLoad,
        kindStore
    } xferKind_e;

    typedef enum logic [1:0] {
        stIdle,
        stFetch,
        stLoad,
        stStore
    } arbState_e;

endpackage

// File: design/memArbiter.sv
`timescale 1ns/1ps

module memArbiter #(
    parameter int addrWidth = 17
) (
    input  logic                             clk,
    input  logic                             rst,

    input  logic                             i_fCyc,
    input  logic                             i_fStb,
    input  logic [addrWidth-1:0]             i_fAddr,
    output logic                             o_fAck,
    output logic [memCtrlPkg::wordWidth-1:0] o_fInst,

    input  logic                             i_dCyc,
    input  logic                             i_dStb,
    input  logic                             i_dWe,
    input  memCtrlPkg::accessLen_e           i_dLen,
    input  logic [addrWidth-1:0]             i_dAddr,
    input  logic [memCtrlPkg::wordWidth-1:0] i_dWdata,
    output logic                             o_dAck,
    output logic [memCtrlPkg::wordWidth-1:0] o_dRdata,

    output logic                             o_start,
    output memCtrlPkg::xferKind_e            o_kind,
    output memCtrlPkg::accessLen_e           o_len,
    output logic [addrWidth-1:0]             o_baseAddr,
    output logic [memCtrlPkg::wordWidth-1:0] o_wdata,
    input  logic                             i_done,
    input  logic [memCtrlPkg::wordWidth-1:0] i_rdata
);
    import memCtrlPkg::*;

    arbState_e state;
    logic      fReq;
    logic      dReq;

    // in its ack cycle a port still shows the old request
    assign fReq = i_fCyc & i_fStb & ~o_fAck;
    assign dReq = i_dCyc & i_dStb & ~o_dAck;

    always_comb begin
        case (state)
            stLoad:  o_kind = kindLoad;
            stStore: o_kind = kindStore;
            default: o_kind = kindFetch;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= stIdle;
            o_start <= 1'b0;
            o_fAck  <= 1'b0;
            o_dAck  <= 1'b0;
        end else begin
            o_start <= 1'b0;
            o_fAck  <= 1'b0;
            o_dAck  <= 1'b0;
            case (state)
                stIdle: begin
                    // data side wins a tie
                    if (dReq) begin
                        if (i_dWe) begin
                            state <= stStore;
                        end else begin
                            state <= stLoad;
                        end
                        o_start <= 1'b1;
                    end else if (fReq) begin
                        state   <= stFetch;
                        o_start <= 1'b1;
                    end
                end
                stFetch: begin
                    if (i_done) begin
                        state  <= stIdle;
                        o_fAck <= 1'b1;
                    end
                end
                default: begin
                    if (i_done) begin
                        state  <= stIdle;
                        o_dAck <= 1'b1;
                    end
                end
            endcase
        end
    end

    // request latch and result registers
    always_ff @(posedge clk) begin
        if (state == stIdle) begin
            if (dReq) begin
                o_baseAddr <= i_dAddr;
                o_len      <= i_dLen;
                o_wdata    <= i_dWdata;
            end else if (fReq) begin
                o_baseAddr <= i_fAddr;
                o_len      <= len4;
            end
        end
        if (i_done && state == stFetch) begin
            o_fInst <= i_rdata;
        end
        if (i_done && state == stLoad) begin
            o_dRdata <= i_rdata;
        end
    end

endmodule

// File: design/byteEngine.sv
`timescale 1ns/1ps

module byteEngine #(
    parameter int addrWidth = 17
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             i_rdy,
    input  logic                             i_ioBufferFull,
    input  logic                             i_start,
    input  memCtrlPkg::xferKind_e            i_kind,
    input  memCtrlPkg::accessLen_e           i_len,
    input  logic [addrWidth-1:0]             i_baseAddr,
    input  logic [memCtrlPkg::wordWidth-1:0] i_wdata,
    input  logic [memCtrlPkg::byteWidth-1:0] i_memRdata,
    output logic                             o_done,
    output logic [memCtrlPkg::wordWidth-1:0] o_rdata,
    output logic                             o_memWe,
    output logic [addrWidth-1:0]             o_memAddr,
    output logic [memCtrlPkg::byteWidth-1:0] o_memWdata
);
    import memCtrlPkg::*;

    localparam int laneWidth = $clog2(bytesPerWord);
    localparam int cntWidth  = laneWidth + 1;

    logic                 active;
    xferKind_e            kindR;
    logic [cntWidth-1:0]  byteCnt;
    logic [addrWidth-1:0] baseR;
    logic [wordWidth-1:0] wdataR;
    logic [wordWidth-1:0] assembly;
    logic [cntWidth-1:0]  issueCnt;
    logic [cntWidth-1:0]  capCnt;
    logic                 rdPend;
    logic                 stall;
    logic                 isRead;
    logic                 issue;
    logic                 capture;
    logic                 lastCapture;
    logic                 lastWrite;

    function automatic logic [cntWidth-1:0] lenToCount(accessLen_e len);
        case (len)
            len1:    return cntWidth'(1);
            len2:    return cntWidth'(2);
            default: return cntWidth'(bytesPerWord);
        endcase
    endfunction

    assign stall   = ~i_rdy | i_ioBufferFull;
    assign isRead  = (kindR != kindStore);
    assign issue   = active & ~stall & (issueCnt < byteCnt);
    // a byte is on i_memRdata one cycle after its address
    assign capture = rdPend & ~stall;

    assign lastCapture = capture & (capCnt == byteCnt - cntWidth'(1));
    assign lastWrite   = issue & ~isRead & (issueCnt == byteCnt - cntWidth'(1));
    assign o_done      = lastCapture | lastWrite;

    assign o_memWe    = issue & ~isRead;
    assign o_memAddr  = baseR + addrWidth'(issueCnt);
    assign o_memWdata = wdataR[issueCnt[laneWidth-1:0]*byteWidth +: byteWidth];

    // last byte merged straight in so done and data line up
    always_comb begin
        o_rdata = assembly;
        o_rdata[capCnt[laneWidth-1:0]*byteWidth +: byteWidth] = i_memRdata;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            active   <= 1'b0;
            issueCnt <= '0;
            capCnt   <= '0;
            rdPend   <= 1'b0;
        end else if (i_start) begin
            active   <= 1'b1;
            issueCnt <= '0;
            capCnt   <= '0;
            rdPend   <= 1'b0;
        end else if (o_done) begin
            active <= 1'b0;
            rdPend <= 1'b0;
        end else if (stall) begin
            // byte in flight is dropped, so its address goes out again
            rdPend <= 1'b0;
            if (isRead) begin
                issueCnt <= capCnt;
            end
        end else begin
            if (issue) begin
                issueCnt <= issueCnt + cntWidth'(1);
            end
            if (capture) begin
                capCnt <= capCnt + cntWidth'(1);
            end
            rdPend <= issue & isRead;
        end
    end

    always_ff @(posedge clk) begin
        if (i_start) begin
            kindR    <= i_kind;
            byteCnt  <= lenToCount(i_len);
            baseR    <= i_baseAddr;
            wdataR   <= i_wdata;
            // upper lanes stay zero for short loads
            assembly <= '0;
        end else if (capture) begin
            assembly[capCnt[laneWidth-1:0]*byteWidth +: byteWidth] <= i_memRdata;
        end
    end

endmodule

// File: design/memCtrlTop.sv
`timescale 1ns/1ps

module memCtrlTop #(
    parameter int addrWidth = 17
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             i_rdy,
    input  logic                             i_ioBufferFull,

    input  logic                             i_fCyc,
    input  logic                             i_fStb,
    input  logic [addrWidth-1:0]             i_fAddr,
    output logic                             o_fAck,
    output logic [memCtrlPkg::wordWidth-1:0] o_fInst,

    input  logic                             i_dCyc,
    input  logic                             i_dStb,
    input  logic                             i_dWe,
    input  memCtrlPkg::accessLen_e           i_dLen,
    input  logic [addrWidth-1:0]             i_dAddr,
    input  logic [memCtrlPkg::wordWidth-1:0] i_dWdata,
    output logic                             o_dAck,
    output logic [memCtrlPkg::wordWidth-1:0] o_dRdata,

    output logic                             o_memWe,
    output logic [addrWidth-1:0]             o_memAddr,
    output logic [memCtrlPkg::byteWidth-1:0] o_memWdata,
    input  logic [memCtrlPkg::byteWidth-1:0] i_memRdata
);
    import memCtrlPkg::*;

    logic                 start;
    xferKind_e            kind;
    accessLen_e           len;
    logic [addrWidth-1:0] baseAddr;
    logic [wordWidth-1:0] wdata;
    logic                 done;
    logic [wordWidth-1:0] rdata;

    memArbiter #(
        .addrWidth (addrWidth)
    ) memArbiter_i (
        .clk        (clk),
        .rst        (rst),
        .i_fCyc     (i_fCyc),
        .i_fStb     (i_fStb),
        .i_fAddr    (i_fAddr),
        .o_fAck     (o_fAck),
        .o_fInst    (o_fInst),
        .i_dCyc     (i_dCyc),
        .i_dStb     (i_dStb),
        .i_dWe      (i_dWe),
        .i_dLen     (i_dLen),
        .i_dAddr    (i_dAddr),
        .i_dWdata   (i_dWdata),
        .o_dAck     (o_dAck),
        .o_dRdata   (o_dRdata),
        .o_start    (start),
        .o_kind     (kind),
        .o_len      (len),
        .o_baseAddr (baseAddr),
        .o_wdata    (wdata),
        .i_done     (done),
        .i_rdata    (rdata)
    );

    // sole master of the RAM port
    byteEngine #(
        .addrWidth (addrWidth)
    ) byteEngine_i (
        .clk            (clk),
        .rst            (rst),
        .i_rdy          (i_rdy),
        .i_ioBufferFull (i_ioBufferFull),
        .i_start        (start),
        .i_kind         (kind),
        .i_len          (len),
        .i_baseAddr     (baseAddr),
        .i_wdata        (wdata),
        .i_memRdata     (i_memRdata),
        .o_done         (done),
        .o_rdata        (rdata),
        .o_memWe        (o_memWe),
        .o_memAddr      (o_memAddr),
        .o_memWdata     (o_memWdata)
    );

endmodule

// File: tests/byteRam.sv
`timescale 1ns/1ps

module byteRam #(
    parameter int addrWidth = 17
) (
    input  logic                             clk,
    input  logic                             i_we,
    input  logic [addrWidth-1:0]             i_addr,
    input  logic [memCtrlPkg::byteWidth-1:0] i_wdata,
    output logic [memCtrlPkg::byteWidth-1:0] o_rdata
);
    import memCtrlPkg::*;

    localparam int depth = 1 << addrWidth;

    logic [byteWidth-1:0] mem [0:depth-1];

    // read data follows the address by one cycle
    always @(posedge clk) begin
        o_rdata <= mem[i_addr];
        if (i_we) begin
            mem[i_addr] = i_wdata;
        end
    end

    task automatic preload(input logic [addrWidth-1:0] addr, input logic [byteWidth-1:0] data);
        mem[addr] = data;
    endtask

endmodule

// File: tests/memCtrl_chk.sv
`timescale 1ns/1ps

module memCtrl_chk (
    input logic clk,
    input logic rst,
    input logic i_rdy,
    input logic i_ioBufferFull,
    input logic i_fCyc,
    input logic i_fStb,
    input logic o_fAck,
    input logic i_dCyc,
    input logic i_dStb,
    input logic o_dAck,
    input logic o_memWe
);

    // one peer served at a time
    ackExclusive: assert property (@(posedge clk) disable iff (rst) !(o_fAck && o_dAck))
        else $error("fetch ack and data ack high in the same cycle");

    fAckInCycle: assert property (@(posedge clk) disable iff (rst)
        o_fAck |-> (i_fCyc && i_fStb))
        else $error("fetch ack without a standing fetch request");

    dAckInCycle: assert property (@(posedge clk) disable iff (rst)
        o_dAck |-> (i_dCyc && i_dStb))
        else $error("data ack without a standing data request");

    noWriteInStall: assert property (@(posedge clk) disable iff (rst)
        (!i_rdy || i_ioBufferFull) |-> !o_memWe)
        else $error("RAM write enable high during a stall");

endmodule

bind memCtrlTop memCtrl_chk memCtrl_chk_i (
    .clk            (clk),
    .rst            (rst),
    .i_rdy          (i_rdy),
    .i_ioBufferFull (i_ioBufferFull),
    .i_fCyc         (i_fCyc),
    .i_fStb         (i_fStb),
    .o_fAck         (o_fAck),
    .i_dCyc         (i_dCyc),
    .i_dStb         (i_dStb),
    .o_dAck         (o_dAck),
    .o_memWe        (o_memWe)
);

// File: tests/memCtrlTb.sv
`timescale 1ns/1ps

module memCtrlTb;
    import memCtrlPkg::*;

    localparam int addrWidth  = 17;
    localparam int ramDepth   = 1 << addrWidth;
    localparam int ackTimeout = 2000;

    logic                 clk          = 1'b0;
    logic                 rdy          = 1'b1;
    logic                 ioBufferFull = 1'b0;
    logic                 rst;
    logic                 fCyc;
    logic                 fStb;
    logic [addrWidth-1:0] fAddr;
    logic                 fAck;
    logic [wordWidth-1:0] fInst;
    logic                 dCyc;
    logic                 dStb;
    logic                 dWe;
    accessLen_e           dLen;
    logic [addrWidth-1:0] dAddr;
    logic [wordWidth-1:0] dWdata;
    logic                 dAck;
    logic [wordWidth-1:0] dRdata;
    logic                 memWe;
    logic [addrWidth-1:0] memAddr;
    logic [byteWidth-1:0] memWdata;
    logic [byteWidth-1:0] memRdata;

    int                   seed       = 32'h91df;
    logic                 stallOn    = 1'b0;
    int                   cycleCnt   = 0;
    int                   errorCount = 0;
    int                   testsPassed = 0;
    int                   testsFailed = 0;
    logic [byteWidth-1:0] mirror [0:ramDepth-1];

    memCtrlTop #(
        .addrWidth (addrWidth)
    ) memCtrlTop_i (
        .clk            (clk),
        .rst            (rst),
        .i_rdy          (rdy),
        .i_ioBufferFull (ioBufferFull),
        .i_fCyc         (fCyc),
        .i_fStb         (fStb),
        .i_fAddr        (fAddr),
        .o_fAck         (fAck),
        .o_fInst        (fInst),
        .i_dCyc         (dCyc),
        .i_dStb         (dStb),
        .i_dWe          (dWe),
        .i_dLen         (dLen),
        .i_dAddr        (dAddr),
        .i_dWdata       (dWdata),
        .o_dAck         (dAck),
        .o_dRdata       (dRdata),
        .o_memWe        (memWe),
        .o_memAddr      (memAddr),
        .o_memWdata     (memWdata),
        .i_memRdata     (memRdata)
    );

    byteRam #(
        .addrWidth (addrWidth)
    ) byteRam_i (
        .clk     (clk),
        .i_we    (memWe),
        .i_addr  (memAddr),
        .i_wdata (memWdata),
        .o_rdata (memRdata)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycleCnt <= cycleCnt + 1;
    end

    // random stall pattern while stallOn is set
    always @(negedge clk) begin
        if (stallOn) begin
            rdy          = (($random(seed) & 3) != 0);
            ioBufferFull = (($random(seed) & 7) == 0);
        end else begin
            rdy          = 1'b1;
            ioBufferFull = 1'b0;
        end
    end

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, expected, actual);
            errorCount++;
        end
    endtask

    task automatic reportTimeout(input string what);
        $display("Timeout: %s within %0d cycles", what, ackTimeout);
        errorCount++;
    endtask

    function automatic int byteCount(input accessLen_e len);
        case (len)
            len1:    return 1;
            len2:    return 2;
            default: return 4;
        endcase
    endfunction

    // little-endian, zero-extended read from the mirror
    function automatic logic [wordWidth-1:0] mirrorRead(input logic [addrWidth-1:0] addr,
                                                        input int n);
        logic [wordWidth-1:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value[8*i +: 8] = mirror[addr + addrWidth'(i)];
        end
        return value;
    endfunction

    task automatic mirrorStore(input logic [addrWidth-1:0] addr, input accessLen_e len,
                               input logic [wordWidth-1:0] wdata);
        for (int i = 0; i < byteCount(len); i++) begin
            mirror[addr + addrWidth'(i)] = wdata[8*i +: 8];
        end
    endtask

    function automatic logic [addrWidth-1:0] randAddr();
        return addrWidth'($unsigned($random(seed)) % (ramDepth - 4));
    endfunction

    function automatic accessLen_e randLen();
        case ($unsigned($random(seed)) % 3)
            0:       return len1;
            1:       return len2;
            default: return len4;
        endcase
    endfunction

    task automatic fetchWord(input logic [addrWidth-1:0] addr, output logic [wordWidth-1:0] inst,
                             output int latency, output int ackCycle);
        @(negedge clk);
        fCyc  = 1'b1;
        fStb  = 1'b1;
        fAddr = addr;
        latency = 1;
        @(negedge clk);
        while (!fAck && latency < ackTimeout) begin
            @(negedge clk);
            latency++;
        end
        if (!fAck) begin
            reportTimeout("fetch ack did not arrive");
        end
        inst     = fInst;
        ackCycle = cycleCnt;
        @(negedge clk);
        fCyc = 1'b0;
        fStb = 1'b0;
    endtask

    task automatic dataAccess(input logic we, input accessLen_e len,
                              input logic [addrWidth-1:0] addr, input logic [wordWidth-1:0] wdata,
                              output logic [wordWidth-1:0] rdata, output int latency,
                              output int ackCycle);
        @(negedge clk);
        dCyc   = 1'b1;
        dStb   = 1'b1;
        dWe    = we;
        dLen   = len;
        dAddr  = addr;
        dWdata = wdata;
        latency = 1;
        @(negedge clk);
        while (!dAck && latency < ackTimeout) begin
            @(negedge clk);
            latency++;
        end
        if (!dAck) begin
            reportTimeout("data ack did not arrive");
        end
        rdata    = dRdata;
        ackCycle = cycleCnt;
        @(negedge clk);
        dCyc = 1'b0;
        dStb = 1'b0;
    endtask

    task automatic finishTest(input string name, input int errBefore);
        if (errorCount == errBefore) begin
            testsPassed++;
            $display("test %s: passed", name);
        end else begin
            testsFailed++;
            $display("test %s: failed with %0d mismatches", name, errorCount - errBefore);
        end
    endtask

    task automatic testFetch();
        int                   errBefore;
        logic [addrWidth-1:0] addr;
        logic [wordWidth-1:0] inst;
        int                   latency;
        int                   ackCycle;
        errBefore = errorCount;
        for (int n = 0; n < 4; n++) begin
            addr = randAddr();
            fetchWord(addr, inst, latency, ackCycle);
            checkValue("o_fInst", mirrorRead(addr, 4), inst);
            checkValue("fetch latency", 32'd7, 32'(latency));
        end
        finishTest("fetch", errBefore);
    endtask

    task automatic testStoreLoad();
        int                   errBefore;
        logic [addrWidth-1:0] addr;
        logic [wordWidth-1:0] wdata;
        logic [wordWidth-1:0] rdata;
        accessLen_e           len;
        int                   latency;
        int                   ackCycle;
        errBefore = errorCount;
        for (int n = 0; n < 6; n++) begin
            len   = (n % 3 == 0) ? len1 : ((n % 3 == 1) ? len2 : len4);
            addr  = randAddr();
            wdata = $random(seed);
            dataAccess(1'b1, len, addr, wdata, rdata, latency, ackCycle);
            checkValue("store latency", 32'(byteCount(len) + 2), 32'(latency));
            mirrorStore(addr, len, wdata);
            dataAccess(1'b0, len4, addr, '0, rdata, latency, ackCycle);
            checkValue("o_dRdata", mirrorRead(addr, 4), rdata);
            checkValue("load latency", 32'd7, 32'(latency));
        end
        finishTest("store then load", errBefore);
    endtask

    task automatic testZeroExtend();
        int                   errBefore;
        logic [addrWidth-1:0] addr;
        logic [wordWidth-1:0] rdata;
        accessLen_e           len;
        int                   latency;
        int                   ackCycle;
        errBefore = errorCount;
        for (int n = 0; n < 4; n++) begin
            len  = n[0] ? len2 : len1;
            addr = randAddr();
            dataAccess(1'b0, len, addr, '0, rdata, latency, ackCycle);
            checkValue("o_dRdata", mirrorRead(addr, byteCount(len)), rdata);
            checkValue("o_dRdata upper bits", 32'd0, rdata >> (8 * byteCount(len)));
        end
        finishTest("zero extension", errBefore);
    endtask

    task automatic testPriority();
        int                   errBefore;
        logic [addrWidth-1:0] addr;
        logic [wordWidth-1:0] wdata;
        logic [wordWidth-1:0] rdata;
        logic [wordWidth-1:0] inst;
        int                   dLatency;
        int                   fLatency;
        int                   dAckCycle;
        int                   fAckCycle;
        errBefore = errorCount;
        addr  = randAddr();
        wdata = $random(seed);
        // fetch overlaps three of the stored bytes
        fork
            dataAccess(1'b1, len4, addr, wdata, rdata, dLatency, dAckCycle);
            fetchWord(addr + addrWidth'(1), inst, fLatency, fAckCycle);
        join
        mirrorStore(addr, len4, wdata);
        checkValue("data ack first", 32'd1, 32'(dAckCycle < fAckCycle));
        checkValue("fetch ack delay", 32'd7, 32'(fAckCycle - dAckCycle));
        checkValue("o_fInst", mirrorRead(addr + addrWidth'(1), 4), inst);
        finishTest("priority", errBefore);
    endtask

    task automatic testStalls();
        int                   errBefore;
        logic [addrWidth-1:0] addr;
        logic [wordWidth-1:0] wdata;
        logic [wordWidth-1:0] rdata;
        accessLen_e           len;
        int                   latency;
        int                   ackCycle;
        errBefore = errorCount;
        stallOn = 1'b1;
        for (int n = 0; n < 40; n++) begin
            addr  = randAddr();
            len   = randLen();
            wdata = $random(seed);
            case ($unsigned($random(seed)) % 3)
                0: begin
                    fetchWord(addr, rdata, latency, ackCycle);
                    checkValue("o_fInst", mirrorRead(addr, 4), rdata);
                end
                1: begin
                    dataAccess(1'b0, len, addr, '0, rdata, latency, ackCycle);
                    checkValue("o_dRdata", mirrorRead(addr, byteCount(len)), rdata);
                end
                default: begin
                    dataAccess(1'b1, len, addr, wdata, rdata, latency, ackCycle);
                    mirrorStore(addr, len, wdata);
                end
            endcase
        end
        stallOn = 1'b0;
        finishTest("stalls", errBefore);
    endtask

    initial begin
        logic [byteWidth-1:0] b;
        rst    = 1'b1;
        fCyc   = 1'b0;
        fStb   = 1'b0;
        fAddr  = '0;
        dCyc   = 1'b0;
        dStb   = 1'b0;
        dWe    = 1'b0;
        dLen   = len1;
        dAddr  = '0;
        dWdata = '0;
        for (int i = 0; i < ramDepth; i++) begin
            b = 8'($random(seed));
            mirror[i] = b;
            byteRam_i.preload(addrWidth'(i), b);
        end
        repeat (4) @(negedge clk);
        rst = 1'b0;

        testFetch();
        testStoreLoad();
        testZeroExtend();
        testPriority();
        testStalls();

        $display("tests passed: %0d, tests failed: %0d", testsPassed, testsFailed);
        if (testsFailed == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: build.f
design/memCtrlPkg.sv
design/memArbiter.sv
design/byteEngine.sv
design/memCtrlTop.sv
tests/byteRam.sv
tests/memCtrl_chk.sv
tests/memCtrlTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module memCtrlTb -o memCtrlTb

out=$(./obj_dir/memCtrlTb 2>&1) || true
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -qx 'Everything OK'
